// File: build.f
+incdir+logic
logic/cu_state_pkg.sv
logic/cu_ctrl_pkg.sv
logic/cu_reg_field_decoder.sv
logic/cu_sequencer.sv
logic/cu_microop_decoder.sv
logic/control_unit.sv
test/tb_clock_gen.sv
test/cu_assertions.sv
test/tb_control_unit.sv

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit
    import cu_state_pkg::*;
    import cu_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  cu_status_e status,
    input  logic       Z,
    input  cu_instr_u  instruction,
    output cu_we_t     write_enable,
    output cu_re_e     read_enable,
    output cu_inc_t    increment,
    output cu_alu_e    alu,
    output logic       finish
);

    cu_state_e state;
    cu_we_t    field_we;
    cu_re_e    field_re;

    cu_sequencer sequencer_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .status      (status),
        .Z           (Z),
        .instruction (instruction),
        .state       (state)
    );

    cu_reg_field_decoder field_decoder_i (
        .instruction (instruction),
        .field_we    (field_we),
        .field_re    (field_re)
    );

    // Outputs are a pure function of state and IR
    cu_microop_decoder microop_decoder_i (
        .state        (state),
        .instruction  (instruction),
        .field_we     (field_we),
        .field_re     (field_re),
        .write_enable (write_enable),
        .read_enable  (read_enable),
        .increment    (increment),
        .alu          (alu),
        .finish       (finish)
    );

endmodule

// File: logic/cu_ctrl_pkg.sv
`include "cu_defs.svh"

package cu_ctrl_pkg;

    // Register write enables, one-hot
    typedef logic [`CU_WE_W-1:0] cu_we_t;

    // Bit 0 is the data memory write, never raised by this unit
    localparam cu_we_t NO_W     = '0;
    localparam cu_we_t ALU_AC_W = cu_we_t'(1) << 1;
    localparam cu_we_t IR_PC_W  = cu_we_t'(1) << 2;
    localparam cu_we_t IR_W     = cu_we_t'(1) << 3;
    localparam cu_we_t AR_W     = cu_we_t'(1) << 4;
    localparam cu_we_t X_W      = cu_we_t'(1) << 5;
    localparam cu_we_t Y_W      = cu_we_t'(1) << 6;
    localparam cu_we_t Z_W      = cu_we_t'(1) << 7;
    localparam cu_we_t STXY_W   = cu_we_t'(1) << 8;
    localparam cu_we_t STYZ_W   = cu_we_t'(1) << 9;
    localparam cu_we_t STXZ_W   = cu_we_t'(1) << 10;
    localparam cu_we_t R_W      = cu_we_t'(1) << 11;
    localparam cu_we_t R1_W     = cu_we_t'(1) << 12;
    localparam cu_we_t R2_W     = cu_we_t'(1) << 13;
    localparam cu_we_t R3_W     = cu_we_t'(1) << 14;
    localparam cu_we_t DR_W     = cu_we_t'(1) << 15;
    localparam cu_we_t AC_W     = cu_we_t'(1) << 16;

    // Bus source select
    typedef enum logic [`CU_RE_W-1:0] {
        NO_R       = 0,
        INS_MEM_R  = 1,
        DATA_MEM_R = 2,
        IR_R       = 4,
        AC_R       = 6,
        X_R        = 7,
        Y_R        = 8,
        Z_R        = 9,
        STXY_R     = 10,
        STYZ_R     = 11,
        STXZ_R     = 12,
        R_R        = 13,
        R1_R       = 14,
        R2_R       = 15,
        R3_R       = 16,
        DR_R       = 17
    } cu_re_e;

    // Increment strobes, bits 5 and 6 held low
    typedef logic [`CU_INC_W-1:0] cu_inc_t;

    localparam cu_inc_t NO_I   = '0;
    localparam cu_inc_t PC_I   = cu_inc_t'(1) << 0;
    localparam cu_inc_t AC_I   = cu_inc_t'(1) << 1;
    localparam cu_inc_t STXY_I = cu_inc_t'(1) << 2;
    localparam cu_inc_t STXZ_I = cu_inc_t'(1) << 3;
    localparam cu_inc_t R_I    = cu_inc_t'(1) << 4;

    typedef enum logic [`CU_ALU_W-1:0] {
        NO_OP = 3'd0,
        ADD   = 3'd1,
        SUB   = 3'd3,
        SFTR  = 3'd4,
        SFTL  = 3'd5,
        ZERO  = 3'd6
    } cu_alu_e;

    typedef struct packed {
        logic [`CU_OPCODE_W-1:0]          opcode;
        logic [`CU_INSTR_W-`CU_OPCODE_W-5:0] unused;
        logic [3:0]                       reg_sel;  // MVAC, MOVREG, MOVAR
    } cu_move_s;

    typedef struct packed {
        logic [`CU_OPCODE_W-1:0]          opcode;
        logic [`CU_INSTR_W-`CU_OPCODE_W-3:0] unused;
        logic [1:0]                       add_src;  // R, R1 or R2 for ADD
    } cu_alu_s;

    typedef union packed {
        cu_move_s mv;
        cu_alu_s  alu;
    } cu_instr_u;

endpackage

// File: logic/cu_defs.svh
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

// Instruction word as held by the datapath IR
`define CU_INSTR_W  16
`define CU_OPCODE_W 8   // Upper byte of the instruction

// Sequencer state code
`define CU_STATE_W  6

// Control word widths driven toward the datapath
`define CU_WE_W     17  // One bit per register destination
`define CU_RE_W     5   // Bus source select code
`define CU_INC_W    7   // Increment strobes
`define CU_ALU_W    3   // ALU operation code

`endif

// File: logic/cu_microop_decoder.sv
`timescale 1ns/1ps

module cu_microop_decoder
    import cu_state_pkg::*;
    import cu_ctrl_pkg::*;
(
    input  cu_state_e state,
    input  cu_instr_u instruction,
    input  cu_we_t    field_we,
    input  cu_re_e    field_re,
    output cu_we_t    write_enable,
    output cu_re_e    read_enable,
    output cu_inc_t   increment,
    output cu_alu_e   alu,
    output logic      finish
);

    always_comb
    begin
        write_enable = NO_W;
        read_enable  = NO_R;
        increment    = NO_I;
        alu          = NO_OP;
        finish       = 1'b0;

        case (state)
            // Instruction fetch, shared with LODAC operand and JUMP target
            FETCH1, LODAC1, JUMP1:
                read_enable = INS_MEM_R;
            FETCH2, LODAC2, JUMP2:
            begin
                write_enable = IR_W;
                read_enable  = INS_MEM_R;
            end
            FETCH3, JUMPZN, JMNZN:
                increment = PC_I;

            ADD1:
            begin
                alu = ADD;
                case (instruction.alu.add_src)
                    2'd1:    read_enable = R_R;
                    2'd2:    read_enable = R1_R;
                    2'd3:    read_enable = R2_R;
                    default: read_enable = NO_R;
                endcase
            end
            SUB1:
            begin
                read_enable = R_R;
                alu         = SUB;
            end
            CLAC1:
                alu = ZERO;
            SFTR1:
                alu = SFTR;
            SFTL1:
                alu = SFTL;
            ADD2, SUB2, CLAC2, SFTR2, SFTL2:
                write_enable = ALU_AC_W;  // Latch ALU result

            LODAC3:
            begin
                write_enable = AR_W;
                read_enable  = IR_R;
                increment    = PC_I;
            end
            LODAC4:
            begin
                write_enable = DR_W;
                read_enable  = DATA_MEM_R;
            end
            LODAC5:
            begin
                write_enable = AC_W;
                read_enable  = DR_R;
            end

            MVAC:
            begin
                write_enable = field_we;
                read_enable  = AC_R;
            end
            MOVREG:
            begin
                write_enable = AC_W;
                read_enable  = field_re;
            end
            MOVAR1:
            begin
                write_enable = AR_W;
                read_enable  = field_re;
            end
            MOVAR2:
                increment = (instruction.mv.reg_sel == 4'd4) ? STXY_I : STXZ_I;

            JUMP3:
                write_enable = IR_PC_W;  // Target into PC
            INCAC:
                increment = AC_I;
            INCR:
                increment = R_I;
            ENDOP:
                finish = 1'b1;

            default:
            begin
                write_enable = NO_W;  // IDLE, NOP and branch tests
                read_enable  = NO_R;
            end
        endcase
    end

endmodule

// File: logic/cu_reg_field_decoder.sv
`timescale 1ns/1ps

module cu_reg_field_decoder
    import cu_ctrl_pkg::*;
(
    input  cu_instr_u instruction,
    output cu_we_t    field_we,
    output cu_re_e    field_re
);

    localparam int unsigned FIELD_MIN = 1;
    localparam int unsigned FIELD_MAX = 11;

    // Field code 1 maps to X, up through 11 for DR
    localparam cu_we_t FIELD_WE [FIELD_MIN:FIELD_MAX] = '{
        X_W, Y_W, Z_W,
        STXY_W, STYZ_W, STXZ_W,
        R_W, R1_W, R2_W, R3_W,
        DR_W
    };

    localparam cu_re_e FIELD_RE [FIELD_MIN:FIELD_MAX] = '{
        X_R, Y_R, Z_R,
        STXY_R, STYZ_R, STXZ_R,
        R_R, R1_R, R2_R, R3_R,
        DR_R
    };

    logic [3:0] reg_sel;
    logic       sel_valid;

    assign reg_sel   = instruction.mv.reg_sel;
    assign sel_valid = (reg_sel >= FIELD_MIN) && (reg_sel <= FIELD_MAX);

    always_comb
    begin
        field_we = NO_W;
        field_re = NO_R;
        if (sel_valid)
        begin
            field_we = FIELD_WE[reg_sel];
            field_re = FIELD_RE[reg_sel];
        end
    end

endmodule

// File: logic/cu_sequencer.sv
`timescale 1ns/1ps

`include "cu_defs.svh"

module cu_sequencer
    import cu_state_pkg::*;
    import cu_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  cu_status_e status,
    input  logic       Z,
    input  cu_instr_u  instruction,
    output cu_state_e  state
);

    cu_state_e  state_nxt;
    cu_opcode_t opcode;
    logic       movar_step;

    assign opcode     = instruction.mv.opcode;
    assign movar_step = (instruction.mv.reg_sel == 4'd4) || (instruction.mv.reg_sel == 4'd6);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    always_comb
    begin
        state_nxt = FETCH1;  // Last step of most instructions
        case (state)
            IDLE:   state_nxt = (status == PROCESS) ? FETCH1 : IDLE;
            FETCH1: state_nxt = FETCH2;
            FETCH2: state_nxt = FETCH3;
            FETCH3:
            begin
                case (opcode)
                    cu_opcode_t'(NOP), cu_opcode_t'(ADD1), cu_opcode_t'(SUB1),
                    cu_opcode_t'(LODAC1), cu_opcode_t'(MVAC), cu_opcode_t'(MOVREG),
                    cu_opcode_t'(CLAC1), cu_opcode_t'(JUMP1), cu_opcode_t'(JUMPZ),
                    cu_opcode_t'(JMNZ), cu_opcode_t'(INCAC), cu_opcode_t'(INCR),
                    cu_opcode_t'(SFTR1), cu_opcode_t'(SFTL1), cu_opcode_t'(MOVAR1),
                    cu_opcode_t'(ENDOP):
                        state_nxt = cu_state_e'(opcode[`CU_STATE_W-1:0]);
                    default:
                        state_nxt = IDLE;  // Unknown opcode
                endcase
            end
            ADD1:   state_nxt = ADD2;
            SUB1:   state_nxt = SUB2;
            CLAC1:  state_nxt = CLAC2;
            SFTR1:  state_nxt = SFTR2;
            SFTL1:  state_nxt = SFTL2;
            LODAC1: state_nxt = LODAC2;
            LODAC2: state_nxt = LODAC3;
            LODAC3: state_nxt = LODAC4;
            LODAC4: state_nxt = LODAC5;
            JUMP1:  state_nxt = JUMP2;
            JUMP2:  state_nxt = JUMP3;
            JUMPZ:  state_nxt = Z ? JUMPZN : JUMP1;
            JMNZ:   state_nxt = Z ? JUMP1 : JMNZN;
            MOVAR1: state_nxt = movar_step ? MOVAR2 : FETCH1;  // Stack pointer bump
            ENDOP:  state_nxt = ENDOP;
            ADD2, SUB2, CLAC2, SFTR2, SFTL2, LODAC5, JUMP3, JUMPZN, JMNZN,
            NOP, MVAC, MOVREG, INCAC, INCR, MOVAR2:
                state_nxt = FETCH1;
            default:
                state_nxt = IDLE;
        endcase
    end

endmodule

// File: logic/cu_state_pkg.sv
`include "cu_defs.svh"

package cu_state_pkg;

    typedef logic [`CU_OPCODE_W-1:0] cu_opcode_t;

    // Start status level from the host
    typedef enum logic [1:0] {
        PREPARE  = 2'b00,
        PROCESS  = 2'b01,
        COMPLETE = 2'b11
    } cu_status_e;

    // First execute state of each instruction doubles as its opcode
    typedef enum logic [`CU_STATE_W-1:0] {
        IDLE   = 0,
        FETCH1 = 1,
        FETCH2 = 2,
        FETCH3 = 3,
        NOP    = 4,
        ADD1   = 5,
        ADD2   = 6,
        SUB1   = 9,
        SUB2   = 10,
        LODAC1 = 11,
        LODAC2 = 12,
        LODAC3 = 13,
        LODAC4 = 14,
        LODAC5 = 15,
        MVAC   = 20,
        MOVREG = 21,
        CLAC1  = 22,
        CLAC2  = 23,
        JUMP1  = 24,
        JUMP2  = 25,
        JUMP3  = 26,
        JUMPZ  = 27,
        JUMPZN = 28,   // Skip cycle, Z set
        JMNZ   = 29,
        JMNZN  = 30,   // Skip cycle, Z clear
        INCAC  = 31,
        INCR   = 32,
        SFTR1  = 34,
        SFTR2  = 35,
        SFTL1  = 36,
        SFTL2  = 37,
        MOVAR1 = 38,
        MOVAR2 = 39,
        ENDOP  = 40
    } cu_state_e;

endpackage

// File: test/cu_assertions.sv
`timescale 1ns/1ps

module cu_assertions
    import cu_ctrl_pkg::*;
(
    input logic    clk,
    input logic    arst_n,
    input cu_we_t  write_enable,
    input cu_re_e  read_enable,
    input cu_inc_t increment,
    input cu_alu_e alu,
    input logic    finish
);

    int unsigned fail_count = 0;  // Failed assertions so far
    logic        outputs_idle;

    assign outputs_idle = (write_enable == NO_W) && (read_enable == NO_R) &&
                          (increment == NO_I) && (alu == NO_OP);

    write_enable_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(write_enable))
    else
    begin
        fail_count++;
        $error("write_enable has more than one bit set");
    end

    finish_quiet: assert property (
        @(posedge clk) disable iff (!arst_n) finish |-> outputs_idle)
    else
    begin
        fail_count++;
        $error("control outputs active while finish is high");
    end

    finish_held: assert property (
        @(posedge clk) disable iff (!arst_n) finish |=> finish)
    else
    begin
        fail_count++;
        $error("finish dropped without a reset");
    end

    // No disable here, reset itself is the condition
    reset_quiet: assert property (
        @(posedge clk) !arst_n |-> (outputs_idle && !finish))
    else
    begin
        fail_count++;
        $error("outputs active during reset");
    end

endmodule

// File: test/cu_input.txt
# status z instruction write_enable read_enable increment alu finish, all in hex
# One line per clock cycle, expected outputs belong to the same cycle
0 0 0000 00000 00 00 0 0
0 0 0000 00000 00 00 0 0
1 0 0000 00000 00 00 0 0
1 0 0400 00000 01 00 0 0
1 0 0400 00008 01 00 0 0
1 0 0400 00000 00 01 0 0
1 0 0400 00000 00 00 0 0
1 0 0501 00000 01 00 0 0
1 0 0501 00008 01 00 0 0
1 0 0501 00000 00 01 0 0
1 0 0501 00000 0d 00 1 0
1 0 0501 00002 00 00 0 0
1 0 0502 00000 01 00 0 0
1 0 0502 00008 01 00 0 0
1 0 0502 00000 00 01 0 0
1 0 0502 00000 0e 00 1 0
1 0 0502 00002 00 00 0 0
1 0 0503 00000 01 00 0 0
1 0 0503 00008 01 00 0 0
1 0 0503 00000 00 01 0 0
1 0 0503 00000 0f 00 1 0
1 0 0503 00002 00 00 0 0
1 0 0900 00000 01 00 0 0
1 0 0900 00008 01 00 0 0
1 0 0900 00000 00 01 0 0
1 0 0900 00000 0d 00 3 0
1 0 0900 00002 00 00 0 0
1 0 1600 00000 01 00 0 0
1 0 1600 00008 01 00 0 0
1 0 1600 00000 00 01 0 0
1 0 1600 00000 00 00 6 0
1 0 1600 00002 00 00 0 0
1 0 2200 00000 01 00 0 0
1 0 2200 00008 01 00 0 0
1 0 2200 00000 00 01 0 0
1 0 2200 00000 00 00 4 0
1 0 2200 00002 00 00 0 0
1 0 2400 00000 01 00 0 0
1 0 2400 00008 01 00 0 0
1 0 2400 00000 00 01 0 0
1 0 2400 00000 00 00 5 0
1 0 2400 00002 00 00 0 0
1 0 0b00 00000 01 00 0 0
1 0 0b00 00008 01 00 0 0
1 0 0b00 00000 00 01 0 0
1 0 0b00 00000 01 00 0 0
1 0 0b00 00008 01 00 0 0
1 0 0b00 00010 04 01 0 0
1 0 0b00 08000 02 00 0 0
1 0 0b00 10000 11 00 0 0
1 0 1f00 00000 01 00 0 0
1 0 1f00 00008 01 00 0 0
1 0 1f00 00000 00 01 0 0
1 0 1f00 00000 00 02 0 0
1 0 2000 00000 01 00 0 0
1 0 2000 00008 01 00 0 0
1 0 2000 00000 00 01 0 0
1 0 2000 00000 00 10 0 0
1 1 1b00 00000 01 00 0 0
1 1 1b00 00008 01 00 0 0
1 1 1b00 00000 00 01 0 0
1 1 1b00 00000 00 00 0 0
1 1 1b00 00000 00 01 0 0
1 0 1b00 00000 01 00 0 0
1 0 1b00 00008 01 00 0 0
1 0 1b00 00000 00 01 0 0
1 0 1b00 00000 00 00 0 0
1 0 1b00 00000 01 00 0 0
1 0 1b00 00008 01 00 0 0
1 0 1b00 00004 00 00 0 0
1 0 1d00 00000 01 00 0 0
1 0 1d00 00008 01 00 0 0
1 0 1d00 00000 00 01 0 0
1 0 1d00 00000 00 00 0 0
1 0 1d00 00000 00 01 0 0
1 1 1d00 00000 01 00 0 0
1 1 1d00 00008 01 00 0 0
1 1 1d00 00000 00 01 0 0
1 1 1d00 00000 00 00 0 0
1 1 1d00 00000 01 00 0 0
1 1 1d00 00008 01 00 0 0
1 1 1d00 00004 00 00 0 0
1 0 3f00 00000 01 00 0 0
1 0 3f00 00008 01 00 0 0
1 0 3f00 00000 00 01 0 0
0 0 3f00 00000 00 00 0 0
1 0 3f00 00000 00 00 0 0
1 0 1400 00000 01 00 0 0
1 0 1400 00008 01 00 0 0
1 0 1400 00000 00 01 0 0
1 0 1400 00000 06 00 0 0
1 0 1401 00000 01 00 0 0
1 0 1401 00008 01 00 0 0
1 0 1401 00000 00 01 0 0
1 0 1401 00020 06 00 0 0
1 0 1402 00000 01 00 0 0
1 0 1402 00008 01 00 0 0
1 0 1402 00000 00 01 0 0
1 0 1402 00040 06 00 0 0
1 0 1403 00000 01 00 0 0
1 0 1403 00008 01 00 0 0
1 0 1403 00000 00 01 0 0
1 0 1403 00080 06 00 0 0
1 0 1404 00000 01 00 0 0
1 0 1404 00008 01 00 0 0
1 0 1404 00000 00 01 0 0
1 0 1404 00100 06 00 0 0
1 0 1405 00000 01 00 0 0
1 0 1405 00008 01 00 0 0
1 0 1405 00000 00 01 0 0
1 0 1405 00200 06 00 0 0
1 0 1406 00000 01 00 0 0
1 0 1406 00008 01 00 0 0
1 0 1406 00000 00 01 0 0
1 0 1406 00400 06 00 0 0
1 0 1407 00000 01 00 0 0
1 0 1407 00008 01 00 0 0
1 0 1407 00000 00 01 0 0
1 0 1407 00800 06 00 0 0
1 0 1408 00000 01 00 0 0
1 0 1408 00008 01 00 0 0
1 0 1408 00000 00 01 0 0
1 0 1408 01000 06 00 0 0
1 0 1409 00000 01 00 0 0
1 0 1409 00008 01 00 0 0
1 0 1409 00000 00 01 0 0
1 0 1409 02000 06 00 0 0
1 0 140a 00000 01 00 0 0
1 0 140a 00008 01 00 0 0
1 0 140a 00000 00 01 0 0
1 0 140a 04000 06 00 0 0
1 0 140b 00000 01 00 0 0
1 0 140b 00008 01 00 0 0
1 0 140b 00000 00 01 0 0
1 0 140b 08000 06 00 0 0
1 0 1501 00000 01 00 0 0
1 0 1501 00008 01 00 0 0
1 0 1501 00000 00 01 0 0
1 0 1501 10000 07 00 0 0
1 0 1502 00000 01 00 0 0
1 0 1502 00008 01 00 0 0
1 0 1502 00000 00 01 0 0
1 0 1502 10000 08 00 0 0
1 0 1503 00000 01 00 0 0
1 0 1503 00008 01 00 0 0
1 0 1503 00000 00 01 0 0
1 0 1503 10000 09 00 0 0
1 0 1504 00000 01 00 0 0
1 0 1504 00008 01 00 0 0
1 0 1504 00000 00 01 0 0
1 0 1504 10000 0a 00 0 0
1 0 1505 00000 01 00 0 0
1 0 1505 00008 01 00 0 0
1 0 1505 00000 00 01 0 0
1 0 1505 10000 0b 00 0 0
1 0 1506 00000 01 00 0 0
1 0 1506 00008 01 00 0 0
1 0 1506 00000 00 01 0 0
1 0 1506 10000 0c 00 0 0
1 0 1507 00000 01 00 0 0
1 0 1507 00008 01 00 0 0
1 0 1507 00000 00 01 0 0
1 0 1507 10000 0d 00 0 0
1 0 1508 00000 01 00 0 0
1 0 1508 00008 01 00 0 0
1 0 1508 00000 00 01 0 0
1 0 1508 10000 0e 00 0 0
1 0 1509 00000 01 00 0 0
1 0 1509 00008 01 00 0 0
1 0 1509 00000 00 01 0 0
1 0 1509 10000 0f 00 0 0
1 0 150a 00000 01 00 0 0
1 0 150a 00008 01 00 0 0
1 0 150a 00000 00 01 0 0
1 0 150a 10000 10 00 0 0
1 0 150b 00000 01 00 0 0
1 0 150b 00008 01 00 0 0
1 0 150b 00000 00 01 0 0
1 0 150b 10000 11 00 0 0
1 0 150c 00000 01 00 0 0
1 0 150c 00008 01 00 0 0
1 0 150c 00000 00 01 0 0
1 0 150c 10000 00 00 0 0
1 0 2601 00000 01 00 0 0
1 0 2601 00008 01 00 0 0
1 0 2601 00000 00 01 0 0
1 0 2601 00010 07 00 0 0
1 0 2602 00000 01 00 0 0
1 0 2602 00008 01 00 0 0
1 0 2602 00000 00 01 0 0
1 0 2602 00010 08 00 0 0
1 0 2603 00000 01 00 0 0
1 0 2603 00008 01 00 0 0
1 0 2603 00000 00 01 0 0
1 0 2603 00010 09 00 0 0
1 0 2604 00000 01 00 0 0
1 0 2604 00008 01 00 0 0
1 0 2604 00000 00 01 0 0
1 0 2604 00010 0a 00 0 0
1 0 2604 00000 00 04 0 0
1 0 2605 00000 01 00 0 0
1 0 2605 00008 01 00 0 0
1 0 2605 00000 00 01 0 0
1 0 2605 00010 0b 00 0 0
1 0 2606 00000 01 00 0 0
1 0 2606 00008 01 00 0 0
1 0 2606 00000 00 01 0 0
1 0 2606 00010 0c 00 0 0
1 0 2606 00000 00 08 0 0
1 0 2607 00000 01 00 0 0
1 0 2607 00008 01 00 0 0
1 0 2607 00000 00 01 0 0
1 0 2607 00010 0d 00 0 0
1 0 2608 00000 01 00 0 0
1 0 2608 00008 01 00 0 0
1 0 2608 00000 00 01 0 0
1 0 2608 00010 0e 00 0 0
1 0 2609 00000 01 00 0 0
1 0 2609 00008 01 00 0 0
1 0 2609 00000 00 01 0 0
1 0 2609 00010 0f 00 0 0
1 0 260a 00000 01 00 0 0
1 0 260a 00008 01 00 0 0
1 0 260a 00000 00 01 0 0
1 0 260a 00010 10 00 0 0
1 0 260b 00000 01 00 0 0
1 0 260b 00008 01 00 0 0
1 0 260b 00000 00 01 0 0
1 0 260b 00010 11 00 0 0
1 0 260f 00000 01 00 0 0
1 0 260f 00008 01 00 0 0
1 0 260f 00000 00 01 0 0
1 0 260f 00010 00 00 0 0
1 0 2800 00000 01 00 0 0
1 0 2800 00008 01 00 0 0
1 0 2800 00000 00 01 0 0
1 0 2800 00000 00 00 0 1
0 0 2800 00000 00 00 0 1
3 1 2800 00000 00 00 0 1
1 0 0400 00000 00 00 0 1
1 1 2604 00000 00 00 0 1

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: test/tb_control_unit.sv
`timescale 1ns/1ps

`include "cu_defs.svh"

module tb_control_unit
    import cu_state_pkg::*;
    import cu_ctrl_pkg::*;
();

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 5;
    localparam int    DRIVE_DELAY  = 1;
    localparam int    SAMPLE_DELAY = CLK_PERIOD - 2;  // 1 ns before the next edge
    localparam string VECTOR_FILE  = "test/cu_input.txt";

    typedef struct packed {
        logic [1:0]             status;
        logic                   z;
        logic [`CU_INSTR_W-1:0] instr;
        logic [`CU_WE_W-1:0]    we;
        logic [`CU_RE_W-1:0]    re;
        logic [`CU_INC_W-1:0]   inc;
        logic [`CU_ALU_W-1:0]   alu_op;
        logic                   fin;
    } vector_t;

    vector_t    vectors[$];
    logic       vectors_loaded;
    logic       clk;
    logic       arst_n;
    cu_status_e status;
    logic       z_flag;
    cu_instr_u  instruction;
    cu_we_t     write_enable;
    cu_re_e     read_enable;
    cu_inc_t    increment;
    cu_alu_e    alu;
    logic       finish;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) clock_gen_i (.clk(clk));

    control_unit dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .status       (status),
        .Z            (z_flag),
        .instruction  (instruction),
        .write_enable (write_enable),
        .read_enable  (read_enable),
        .increment    (increment),
        .alu          (alu),
        .finish       (finish)
    );

    bind control_unit cu_assertions assertions_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .write_enable (write_enable),
        .read_enable  (read_enable),
        .increment    (increment),
        .alu          (alu),
        .finish       (finish)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input int index);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s vector %0d expected %h actual %h",
                     name, index, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          count;
        string       line;
        logic [31:0] f_status, f_z, f_instr, f_we, f_re, f_inc, f_alu, f_fin;
        vector_t     v;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0)
        begin
            $display("Cannot open the vector file %s", VECTOR_FILE);
            $display("=== FAIL ===");
            $fatal(1, "vector file missing");
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#")
                continue;  // Blank or column note
            count = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            f_status, f_z, f_instr, f_we, f_re, f_inc, f_alu, f_fin);
            if (count != 8)
            begin
                $display("Malformed line in the vector file: %s", line);
                $display("=== FAIL ===");
                $fatal(1, "bad vector line");
            end
            v = {f_status[1:0], f_z[0], f_instr[`CU_INSTR_W-1:0], f_we[`CU_WE_W-1:0],
                 f_re[`CU_RE_W-1:0], f_inc[`CU_INC_W-1:0], f_alu[`CU_ALU_W-1:0], f_fin[0]};
            vectors.push_back(v);
        end
        $fclose(fd);
        if (vectors.size() == 0)
        begin
            $display("The vector file holds no vectors");
            $display("=== FAIL ===");
            $fatal(1, "vector file empty");
        end
    endtask

    task automatic apply_vector(input vector_t v);
        status      = cu_status_e'(v.status);
        z_flag      = v.z;
        instruction = v.instr;
    endtask

    task automatic compare_outputs(input vector_t v, input int index);
        check_value("write_enable", 32'(v.we), 32'(write_enable), index);
        check_value("read_enable", 32'(v.re), 32'(read_enable), index);
        check_value("increment", 32'(v.inc), 32'(increment), index);
        check_value("alu", 32'(v.alu_op), 32'(alu), index);
        check_value("finish", 32'(v.fin), 32'(finish), index);
        check_value("assertion failures", 32'd0, 32'(dut_i.assertions_i.fail_count), index);
    endtask

    initial
    begin
        arst_n         = 1'b1;
        status         = PREPARE;
        z_flag         = 1'b0;
        instruction    = '0;
        vectors_loaded = 1'b0;
        load_vectors();
        vectors_loaded = 1'b1;
        #DRIVE_DELAY arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY arst_n = 1'b1;
        for (int i = 0; i < vectors.size(); i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            apply_vector(vectors[i]);
            #SAMPLE_DELAY;
            compare_outputs(vectors[i], i);
        end
        @(posedge clk);  // Let the last cycle reach the assertions
        #DRIVE_DELAY;
        check_value("assertion failures", 32'd0, 32'(dut_i.assertions_i.fail_count),
                    vectors.size());
        $display("=== PASS ===");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (vectors_loaded === 1'b1);
        #((2 * vectors.size() + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the vector run did not complete in time");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule
